// ==== design/cfg_map_pkg.sv ====
// command address map, command widths and the command data word union
package cfg_map_pkg;

    localparam int CMD_ADDR_W = 16;
    localparam int CMD_DATA_W = 32;

    // base addresses, zone tables span 16 words from their base
    localparam logic [15:0] ADDR_DEPTH_MAX   = 16'h0000;
    localparam logic [15:0] ADDR_MATRIX_CAM0 = 16'h0010;
    localparam logic [15:0] ADDR_MATRIX_CAM1 = 16'h0020;
    localparam logic [15:0] ADDR_CONF_MIN    = 16'h0050;
    localparam logic [15:0] ADDR_COL_CENTER  = 16'h0060;
    localparam logic [15:0] ADDR_ROW_CENTER  = 16'h0061;
    localparam logic [15:0] ADDR_RSQ         = 16'h0070;
    // roi corners take two words each, row then column
    localparam logic [15:0] ADDR_ROI_PRE     = 16'h0080;
    localparam logic [15:0] ADDR_ROI_POST    = 16'h0082;

    // matrix coefficient, only the low 11+PRECISION bits are kept
    typedef struct packed {
        logic [CMD_DATA_W-19:0] pad;
        logic signed [17:0]     coeff;
    } coeff_view_t;

    // plain value, upper bits extend the rsq limits
    typedef struct packed {
        logic [CMD_DATA_W-17:0] upper;
        logic [15:0]            value;
    } value_view_t;

    typedef union packed {
        coeff_view_t coeff_view;
        value_view_t value_view;
    } cmd_word_u;

endpackage

// ==== design/pixel_pkg.sv ====
// pixel field widths, zone count and zone index width
package pixel_pkg;

    // coordinates and optical centers
    localparam int COORD_W = 16;

    // per-sample payload
    localparam int DEPTH_W = 16;
    localparam int CONF_W  = 16;

    // radial zones
    localparam int NUM_ZONES = 16;
    localparam int ZONE_W    = 4;

    // radius-squared zone limits
    localparam int RSQ_W = 18;

endpackage

// ==== design/config_controller.sv ====
// configuration register file with command capture, address decode and defaults
module config_controller #(
    parameter int PRECISION = 6
) (
    input  logic                               in,
    input  logic                               rst_n_i,
    input  logic                               cmd_valid_i,
    input  logic [cfg_map_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
    input  logic [cfg_map_pkg::CMD_DATA_W-1:0] cmd_data_i,
    output logic signed [10+PRECISION:0]       matrix_o [2][2][3],
    output logic [pixel_pkg::COORD_W-1:0]      roi_pre_corner_o [2],
    output logic [pixel_pkg::COORD_W-1:0]      roi_post_corner_o [2],
    output logic [pixel_pkg::COORD_W-1:0]      col_center_o,
    output logic [pixel_pkg::COORD_W-1:0]      row_center_o,
    output logic [pixel_pkg::RSQ_W-1:0]        rsq_o [pixel_pkg::NUM_ZONES],
    output logic [pixel_pkg::CONF_W-1:0]       conf_min_o [pixel_pkg::NUM_ZONES],
    output logic [pixel_pkg::DEPTH_W-1:0]      depth_max_o [pixel_pkg::NUM_ZONES]
);
    import cfg_map_pkg::*;
    import pixel_pkg::*;

    localparam int CW = 11 + PRECISION;
    localparam logic signed [CW-1:0] COEFF_ONE = CW'(1 << PRECISION);
    localparam logic [COORD_W-1:0] CENTER_DEFAULT = COORD_W'(200);

    logic                  cmd_valid_q;
    logic [CMD_ADDR_W-1:0] cmd_addr_q;
    cmd_word_u             cmd_q;

    // command capture stage
    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid_i;
        end
        cmd_addr_q <= cmd_addr_i;
        cmd_q      <= cmd_data_i;
    end

    // register file, written one edge after capture
    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            // identity matrices for both cameras
            for (int c = 0; c < 2; c++) begin
                for (int r = 0; r < 2; r++) begin
                    for (int k = 0; k < 3; k++) begin
                        matrix_o[c][r][k] <= (r == k) ? COEFF_ONE : '0;
                    end
                end
            end
            roi_pre_corner_o  <= '{default: '0};
            roi_post_corner_o <= '{default: '0};
            col_center_o      <= CENTER_DEFAULT;
            row_center_o      <= CENTER_DEFAULT;
            // rsq ramp of 4096 per zone
            for (int z = 0; z < NUM_ZONES; z++) begin
                rsq_o[z]       <= RSQ_W'((z + 1) * 4096);
                conf_min_o[z]  <= '0;
                depth_max_o[z] <= DEPTH_W'(16'h7fff);
            end
        end else if (cmd_valid_q) begin
            // matrix words through the signed coefficient view
            // offsets 6..8 would be the projective row and fall through
            for (int c = 0; c < 2; c++) begin
                for (int r = 0; r < 2; r++) begin
                    for (int k = 0; k < 3; k++) begin
                        if (cmd_addr_q == ((c == 0) ? ADDR_MATRIX_CAM0 : ADDR_MATRIX_CAM1)
                                          + CMD_ADDR_W'(3 * r + k)) begin
                            matrix_o[c][r][k] <= cmd_q.coeff_view.coeff[CW-1:0];
                        end
                    end
                end
            end
            // zone tables through the unsigned value view
            for (int z = 0; z < NUM_ZONES; z++) begin
                if (cmd_addr_q == ADDR_DEPTH_MAX + CMD_ADDR_W'(z)) begin
                    depth_max_o[z] <= cmd_q.value_view.value;
                end
                if (cmd_addr_q == ADDR_CONF_MIN + CMD_ADDR_W'(z)) begin
                    conf_min_o[z] <= cmd_q.value_view.value;
                end
                if (cmd_addr_q == ADDR_RSQ + CMD_ADDR_W'(z)) begin
                    rsq_o[z] <= {cmd_q.value_view.upper[RSQ_W-17:0], cmd_q.value_view.value};
                end
            end
            // centers and roi corners, index 0 is the row
            case (cmd_addr_q)
                ADDR_COL_CENTER:        col_center_o <= cmd_q.value_view.value;
                ADDR_ROW_CENTER:        row_center_o <= cmd_q.value_view.value;
                ADDR_ROI_PRE:           roi_pre_corner_o[0] <= cmd_q.value_view.value;
                ADDR_ROI_PRE + 16'd1:   roi_pre_corner_o[1] <= cmd_q.value_view.value;
                ADDR_ROI_POST:          roi_post_corner_o[0] <= cmd_q.value_view.value;
                ADDR_ROI_POST + 16'd1:  roi_post_corner_o[1] <= cmd_q.value_view.value;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/coord_xform.sv ====
// stage 1 affine fixed-point coordinate mapping with per-camera matrix select
module coord_xform #(
    parameter int PRECISION = 6
) (
    input  logic                          in,
    input  logic                          rst_n_i,
    input  logic                          pix_valid_i,
    input  logic                          pix_cam_i,
    input  logic [pixel_pkg::COORD_W-1:0] pix_x_i,
    input  logic [pixel_pkg::COORD_W-1:0] pix_y_i,
    input  logic [pixel_pkg::DEPTH_W-1:0] pix_depth_i,
    input  logic [pixel_pkg::CONF_W-1:0]  pix_conf_i,
    input  logic signed [10+PRECISION:0]  matrix_i [2][2][3],
    output logic                          s1_valid_o,
    output logic [pixel_pkg::COORD_W-1:0] s1_x_o,
    output logic [pixel_pkg::COORD_W-1:0] s1_y_o,
    output logic [pixel_pkg::COORD_W-1:0] s1_mx_o,
    output logic [pixel_pkg::COORD_W-1:0] s1_my_o,
    output logic [pixel_pkg::DEPTH_W-1:0] s1_depth_o,
    output logic [pixel_pkg::CONF_W-1:0]  s1_conf_o
);
    import pixel_pkg::*;

    localparam int CW = 11 + PRECISION;
    // product width plus two guard bits for the three-term sum
    localparam int ACC_W = COORD_W + 1 + CW + 2;

    logic signed [COORD_W:0] sx;
    logic signed [COORD_W:0] sy;
    logic signed [ACC_W-1:0] acc_x;
    logic signed [ACC_W-1:0] acc_y;
    logic [ACC_W-1:0]        mx_full;
    logic [ACC_W-1:0]        my_full;

    // coordinates are unsigned, widen before the signed multiply
    assign sx = signed'({1'b0, pix_x_i});
    assign sy = signed'({1'b0, pix_y_i});

    always_comb begin
        acc_x = matrix_i[pix_cam_i][0][0] * sx
              + matrix_i[pix_cam_i][0][1] * sy
              + matrix_i[pix_cam_i][0][2];
        acc_y = matrix_i[pix_cam_i][1][0] * sx
              + matrix_i[pix_cam_i][1][1] * sy
              + matrix_i[pix_cam_i][1][2];
        mx_full = acc_x >>> PRECISION;
        my_full = acc_y >>> PRECISION;
    end

    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= pix_valid_i;
        end
        // truncate mapped point to coordinate width
        s1_mx_o    <= mx_full[COORD_W-1:0];
        s1_my_o    <= my_full[COORD_W-1:0];
        s1_x_o     <= pix_x_i;
        s1_y_o     <= pix_y_i;
        s1_depth_o <= pix_depth_i;
        s1_conf_o  <= pix_conf_i;
    end

endmodule

// ==== design/roi_window.sv ====
// stage 2 roi boundaries and inside tests for raw and mapped coordinates
module roi_window #(
    parameter int PRE_ROI_H  = 480,
    parameter int PRE_ROI_W  = 512,
    parameter int POST_ROI_H = 480,
    parameter int POST_ROI_W = 512
) (
    input  logic                          in,
    input  logic                          rst_n_i,
    input  logic [pixel_pkg::COORD_W-1:0] s1_x_i,
    input  logic [pixel_pkg::COORD_W-1:0] s1_y_i,
    input  logic [pixel_pkg::COORD_W-1:0] s1_mx_i,
    input  logic [pixel_pkg::COORD_W-1:0] s1_my_i,
    input  logic [pixel_pkg::COORD_W-1:0] roi_pre_corner_i [2],
    input  logic [pixel_pkg::COORD_W-1:0] roi_post_corner_i [2],
    output logic                          s2_in_roi_o
);
    import pixel_pkg::*;

    // one extra bit so corner plus dimension cannot wrap
    logic [COORD_W:0] pre_bottom;
    logic [COORD_W:0] pre_right;
    logic [COORD_W:0] post_bottom;
    logic [COORD_W:0] post_right;
    logic             in_pre;
    logic             in_post;

    // lower bound inclusive, upper bound exclusive
    function automatic logic in_span(input logic [COORD_W-1:0] lo,
                                     input logic [COORD_W:0]   hi,
                                     input logic [COORD_W-1:0] v);
        return ({1'b0, v} >= {1'b0, lo}) && ({1'b0, v} < hi);
    endfunction

    assign pre_bottom  = {1'b0, roi_pre_corner_i[0]} + (COORD_W + 1)'(PRE_ROI_H);
    assign pre_right   = {1'b0, roi_pre_corner_i[1]} + (COORD_W + 1)'(PRE_ROI_W);
    assign post_bottom = {1'b0, roi_post_corner_i[0]} + (COORD_W + 1)'(POST_ROI_H);
    assign post_right  = {1'b0, roi_post_corner_i[1]} + (COORD_W + 1)'(POST_ROI_W);

    // raw point against pre roi, mapped point against post roi
    assign in_pre  = in_span(roi_pre_corner_i[0], pre_bottom, s1_y_i)
                   & in_span(roi_pre_corner_i[1], pre_right, s1_x_i);
    assign in_post = in_span(roi_post_corner_i[0], post_bottom, s1_my_i)
                   & in_span(roi_post_corner_i[1], post_right, s1_mx_i);

    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            s2_in_roi_o <= 1'b0;
        end else begin
            s2_in_roi_o <= in_pre & in_post;
        end
    end

endmodule

// ==== design/zone_gate.sv ====
// radial zone search and per-zone confidence and depth acceptance
module zone_gate (
    input  logic                            in,
    input  logic                            rst_n_i,
    input  logic                            s1_valid_i,
    input  logic [pixel_pkg::COORD_W-1:0]   s1_mx_i,
    input  logic [pixel_pkg::COORD_W-1:0]   s1_my_i,
    input  logic [pixel_pkg::DEPTH_W-1:0]   s1_depth_i,
    input  logic [pixel_pkg::CONF_W-1:0]    s1_conf_i,
    input  logic                            s2_in_roi_i,
    input  logic [pixel_pkg::COORD_W-1:0]   col_center_i,
    input  logic [pixel_pkg::COORD_W-1:0]   row_center_i,
    input  logic [pixel_pkg::RSQ_W-1:0]     rsq_i [pixel_pkg::NUM_ZONES],
    input  logic [pixel_pkg::CONF_W-1:0]    conf_min_i [pixel_pkg::NUM_ZONES],
    input  logic [pixel_pkg::DEPTH_W-1:0]   depth_max_i [pixel_pkg::NUM_ZONES],
    output logic                            out_valid_o,
    output logic                            out_accept_o,
    output logic [pixel_pkg::ZONE_W-1:0]    out_zone_o,
    output logic [pixel_pkg::COORD_W-1:0]   out_x_o,
    output logic [pixel_pkg::COORD_W-1:0]   out_y_o,
    output logic [pixel_pkg::DEPTH_W-1:0]   out_depth_o
);
    import pixel_pkg::*;

    // squares of 17-bit signed offsets plus one carry bit
    localparam int R2_W = 2 * COORD_W + 2;

    logic signed [COORD_W:0] dx;
    logic signed [COORD_W:0] dy;
    logic [R2_W-1:0]         r2;
    logic [ZONE_W-1:0]       zone_next;

    logic                    s2_valid;
    logic [ZONE_W-1:0]       s2_zone;
    logic [COORD_W-1:0]      s2_mx;
    logic [COORD_W-1:0]      s2_my;
    logic [DEPTH_W-1:0]      s2_depth;
    logic [CONF_W-1:0]       s2_conf;

    assign dx = signed'({1'b0, s1_mx_i}) - signed'({1'b0, col_center_i});
    assign dy = signed'({1'b0, s1_my_i}) - signed'({1'b0, row_center_i});
    assign r2 = dx * dx + dy * dy;

    // first limit above r2 wins, last zone catches the rest
    always_comb begin
        zone_next = ZONE_W'(NUM_ZONES - 1);
        for (int k = NUM_ZONES - 1; k >= 0; k--) begin
            if (r2 < R2_W'(rsq_i[k])) begin
                zone_next = ZONE_W'(k);
            end
        end
    end

    // stage 2
    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid_i;
        end
        s2_zone  <= zone_next;
        s2_mx    <= s1_mx_i;
        s2_my    <= s1_my_i;
        s2_depth <= s1_depth_i;
        s2_conf  <= s1_conf_i;
    end

    // stage 3, limits of the sample's own zone
    always_ff @(posedge in) begin
        if (!rst_n_i) begin
            out_valid_o  <= 1'b0;
            out_accept_o <= 1'b0;
        end else begin
            out_valid_o  <= s2_valid;
            out_accept_o <= s2_valid & s2_in_roi_i
                          & (s2_conf >= conf_min_i[s2_zone])
                          & (s2_depth <= depth_max_i[s2_zone]);
        end
        out_zone_o  <= s2_zone;
        out_x_o     <= s2_mx;
        out_y_o     <= s2_my;
        out_depth_o <= s2_depth;
    end

endmodule

// ==== design/dfd_frontend_top.sv ====
// front end top with config controller, coordinate mapping, roi and zone stages
module dfd_frontend_top #(
    parameter int PRECISION  = 6,
    parameter int PRE_ROI_H  = 480,
    parameter int PRE_ROI_W  = 512,
    parameter int POST_ROI_H = 480,
    parameter int POST_ROI_W = 512
) (
    input  logic                               in,
    input  logic                               rst_n_i,
    input  logic                               cmd_valid_i,
    input  logic [cfg_map_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
    input  logic [cfg_map_pkg::CMD_DATA_W-1:0] cmd_data_i,
    input  logic                               pix_valid_i,
    input  logic                               pix_cam_i,
    input  logic [pixel_pkg::COORD_W-1:0]      pix_x_i,
    input  logic [pixel_pkg::COORD_W-1:0]      pix_y_i,
    input  logic [pixel_pkg::DEPTH_W-1:0]      pix_depth_i,
    input  logic [pixel_pkg::CONF_W-1:0]       pix_conf_i,
    output logic                               out_valid_o,
    output logic                               out_accept_o,
    output logic [pixel_pkg::ZONE_W-1:0]       out_zone_o,
    output logic [pixel_pkg::COORD_W-1:0]      out_x_o,
    output logic [pixel_pkg::COORD_W-1:0]      out_y_o,
    output logic [pixel_pkg::DEPTH_W-1:0]      out_depth_o
);
    import pixel_pkg::*;

    // configuration
    logic signed [10+PRECISION:0] matrix [2][2][3];
    logic [COORD_W-1:0]           roi_pre_corner [2];
    logic [COORD_W-1:0]           roi_post_corner [2];
    logic [COORD_W-1:0]           col_center;
    logic [COORD_W-1:0]           row_center;
    logic [RSQ_W-1:0]             rsq [NUM_ZONES];
    logic [CONF_W-1:0]            conf_min [NUM_ZONES];
    logic [DEPTH_W-1:0]           depth_max [NUM_ZONES];

    // stage 1 outputs
    logic                         s1_valid;
    logic [COORD_W-1:0]           s1_x;
    logic [COORD_W-1:0]           s1_y;
    logic [COORD_W-1:0]           s1_mx;
    logic [COORD_W-1:0]           s1_my;
    logic [DEPTH_W-1:0]           s1_depth;
    logic [CONF_W-1:0]            s1_conf;
    logic                         s2_in_roi;

    config_controller #(.PRECISION(PRECISION)) u_config_controller (
        .in(in), .rst_n_i(rst_n_i),
        .cmd_valid_i(cmd_valid_i), .cmd_addr_i(cmd_addr_i), .cmd_data_i(cmd_data_i),
        .matrix_o(matrix),
        .roi_pre_corner_o(roi_pre_corner), .roi_post_corner_o(roi_post_corner),
        .col_center_o(col_center), .row_center_o(row_center),
        .rsq_o(rsq), .conf_min_o(conf_min), .depth_max_o(depth_max)
    );

    coord_xform #(.PRECISION(PRECISION)) u_coord_xform (
        .in(in), .rst_n_i(rst_n_i),
        .pix_valid_i(pix_valid_i), .pix_cam_i(pix_cam_i),
        .pix_x_i(pix_x_i), .pix_y_i(pix_y_i),
        .pix_depth_i(pix_depth_i), .pix_conf_i(pix_conf_i),
        .matrix_i(matrix),
        .s1_valid_o(s1_valid), .s1_x_o(s1_x), .s1_y_o(s1_y),
        .s1_mx_o(s1_mx), .s1_my_o(s1_my),
        .s1_depth_o(s1_depth), .s1_conf_o(s1_conf)
    );

    roi_window #(
        .PRE_ROI_H(PRE_ROI_H), .PRE_ROI_W(PRE_ROI_W),
        .POST_ROI_H(POST_ROI_H), .POST_ROI_W(POST_ROI_W)
    ) u_roi_window (
        .in(in), .rst_n_i(rst_n_i),
        .s1_x_i(s1_x), .s1_y_i(s1_y), .s1_mx_i(s1_mx), .s1_my_i(s1_my),
        .roi_pre_corner_i(roi_pre_corner), .roi_post_corner_i(roi_post_corner),
        .s2_in_roi_o(s2_in_roi)
    );

    zone_gate u_zone_gate (
        .in(in), .rst_n_i(rst_n_i),
        .s1_valid_i(s1_valid), .s1_mx_i(s1_mx), .s1_my_i(s1_my),
        .s1_depth_i(s1_depth), .s1_conf_i(s1_conf), .s2_in_roi_i(s2_in_roi),
        .col_center_i(col_center), .row_center_i(row_center),
        .rsq_i(rsq), .conf_min_i(conf_min), .depth_max_i(depth_max),
        .out_valid_o(out_valid_o), .out_accept_o(out_accept_o), .out_zone_o(out_zone_o),
        .out_x_o(out_x_o), .out_y_o(out_y_o), .out_depth_o(out_depth_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// free-running testbench clock source
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

// ==== testbench/dfd_frontend_checker.sv ====
// bound assertions on output valid latency, accept qualification and reset state
module dfd_frontend_checker (
    input logic in,
    input logic rst_n_i,
    input logic pix_valid_i,
    input logic out_valid_i,
    input logic out_accept_i
);

    // three register stages between a sample and its result
    a_valid_latency: assert property (@(posedge in) disable iff (!rst_n_i)
        out_valid_i == $past(pix_valid_i, 3))
        else $error("out_valid_o does not follow pix_valid_i by three cycles");

    a_accept_needs_valid: assert property (@(posedge in) disable iff (!rst_n_i)
        out_accept_i |-> out_valid_i)
        else $error("out_accept_o high without out_valid_o");

    a_idle_after_reset: assert property (@(posedge in)
        $rose(rst_n_i) |-> !out_valid_i)
        else $error("out_valid_o high in the first cycle after reset");

endmodule

bind dfd_frontend_top dfd_frontend_checker u_checker (
    .in(in),
    .rst_n_i(rst_n_i),
    .pix_valid_i(pix_valid_i),
    .out_valid_i(out_valid_o),
    .out_accept_i(out_accept_o)
);

// ==== testbench/dfd_frontend_monitor.sv ====
// output monitor that queues expected records and compares each DUT result
module dfd_frontend_monitor (
    input  logic        in,
    input  logic        rst_n_i,
    input  logic        pix_valid_i,
    input  logic [15:0] pix_depth_i,
    input  logic        exp_accept_i,
    input  logic [3:0]  exp_zone_i,
    input  logic [15:0] exp_mx_i,
    input  logic [15:0] exp_my_i,
    input  logic        out_valid_i,
    input  logic        out_accept_i,
    input  logic [3:0]  out_zone_i,
    input  logic [15:0] out_x_i,
    input  logic [15:0] out_y_i,
    input  logic [15:0] out_depth_i,
    output int          mismatch_count_o,
    output int          unexpected_count_o,
    output int          pending_o
);

    typedef struct packed {
        logic        accept;
        logic [3:0]  zone;
        logic [15:0] mx;
        logic [15:0] my;
        logic [15:0] depth;
    } expect_t;

    expect_t expected_q[$];
    expect_t rec;

    task automatic check_field(input string name, input int got, input int want);
        if (got != want) begin
            mismatch_count_o++;
            $display("FAILED at time %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    initial begin
        mismatch_count_o   = 0;
        unexpected_count_o = 0;
        pending_o          = 0;
    end

    // one record per sample the DUT takes in
    always @(posedge in) begin
        if (rst_n_i && pix_valid_i) begin
            expected_q.push_back({exp_accept_i, exp_zone_i, exp_mx_i, exp_my_i, pix_depth_i});
        end
    end

    // outputs settle well before the falling edge
    always @(negedge in) begin
        if (rst_n_i && out_valid_i) begin
            if (expected_q.size() == 0) begin
                unexpected_count_o++;
                $display("unexpected output at time %0t with no sample pending", $time);
            end else begin
                rec = expected_q.pop_front();
                check_field("out_accept_o", int'(out_accept_i), int'(rec.accept));
                check_field("out_zone_o", int'(out_zone_i), int'(rec.zone));
                check_field("out_x_o", int'(out_x_i), int'(rec.mx));
                check_field("out_y_o", int'(out_y_i), int'(rec.my));
                check_field("out_depth_o", int'(out_depth_i), int'(rec.depth));
            end
        end
        pending_o = expected_q.size();
    end

endmodule

// ==== testbench/dfd_frontend_tb.sv ====
// testbench top with stimulus file reader, command and pixel driver, watchdog and result
module dfd_frontend_tb;

    localparam int PERIOD = 100;

    logic        in;
    logic        rst_n;
    logic        cmd_valid;
    logic [15:0] cmd_addr;
    logic [31:0] cmd_data;
    logic        pix_valid;
    logic        pix_cam;
    logic [15:0] pix_x;
    logic [15:0] pix_y;
    logic [15:0] pix_depth;
    logic [15:0] pix_conf;
    logic        exp_accept;
    logic [3:0]  exp_zone;
    logic [15:0] exp_mx;
    logic [15:0] exp_my;
    logic        out_valid;
    logic        out_accept;
    logic [3:0]  out_zone;
    logic [15:0] out_x;
    logic [15:0] out_y;
    logic [15:0] out_depth;
    int          mismatches;
    int          unexpected;
    int          pending;
    int          file_errors;
    bit          loaded;
    string       lines[$];

    tb_clock_gen #(.PERIOD(PERIOD)) u_clock (.clk_o(in));

    dfd_frontend_top uut (
        .in(in), .rst_n_i(rst_n),
        .cmd_valid_i(cmd_valid), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
        .pix_valid_i(pix_valid), .pix_cam_i(pix_cam), .pix_x_i(pix_x), .pix_y_i(pix_y),
        .pix_depth_i(pix_depth), .pix_conf_i(pix_conf),
        .out_valid_o(out_valid), .out_accept_o(out_accept), .out_zone_o(out_zone),
        .out_x_o(out_x), .out_y_o(out_y), .out_depth_o(out_depth)
    );

    dfd_frontend_monitor u_monitor (
        .in(in), .rst_n_i(rst_n), .pix_valid_i(pix_valid), .pix_depth_i(pix_depth),
        .exp_accept_i(exp_accept), .exp_zone_i(exp_zone), .exp_mx_i(exp_mx), .exp_my_i(exp_my),
        .out_valid_i(out_valid), .out_accept_i(out_accept), .out_zone_i(out_zone),
        .out_x_i(out_x), .out_y_i(out_y), .out_depth_i(out_depth),
        .mismatch_count_o(mismatches), .unexpected_count_o(unexpected), .pending_o(pending)
    );

    task automatic load_stimulus();
        int    fd;
        int    code;
        string line;
        fd = $fopen("testbench/stimulus_input.txt", "r");
        if (fd == 0) begin
            file_errors++;
            $display("cannot open the stimulus file testbench/stimulus_input.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // one line of the file, one cycle for W and P
    task automatic apply_line(input string line);
        int          n;
        int          cam;
        int          x;
        int          y;
        int          depth;
        int          conf;
        int          acc;
        int          zone;
        int          mx;
        int          my;
        logic [31:0] addr;
        logic [31:0] data;
        case (line[0])
            "W": begin
                if ($sscanf(line, "W %h %h", addr, data) != 2) begin
                    file_errors++;
                    $display("malformed write line in stimulus file: %s", line);
                end
                @(negedge in);
                pix_valid = 1'b0;
                cmd_valid = 1'b1;
                cmd_addr  = addr[15:0];
                cmd_data  = data;
            end
            "P": begin
                if ($sscanf(line, "P %d %d %d %d %d %d %d %d %d",
                            cam, x, y, depth, conf, acc, zone, mx, my) != 9) begin
                    file_errors++;
                    $display("malformed pixel line in stimulus file: %s", line);
                end
                @(negedge in);
                cmd_valid  = 1'b0;
                pix_valid  = 1'b1;
                pix_cam    = cam[0];
                pix_x      = x[15:0];
                pix_y      = y[15:0];
                pix_depth  = depth[15:0];
                pix_conf   = conf[15:0];
                exp_accept = acc[0];
                exp_zone   = zone[3:0];
                exp_mx     = mx[15:0];
                exp_my     = my[15:0];
            end
            "I": begin
                if ($sscanf(line, "I %d", n) != 1) begin
                    file_errors++;
                    $display("malformed idle line in stimulus file: %s", line);
                end
                repeat (n) begin
                    @(negedge in);
                    cmd_valid = 1'b0;
                    pix_valid = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_addr    = '0;
        cmd_data    = '0;
        pix_valid   = 1'b0;
        pix_cam     = 1'b0;
        pix_x       = '0;
        pix_y       = '0;
        pix_depth   = '0;
        pix_conf    = '0;
        exp_accept  = 1'b0;
        exp_zone    = '0;
        exp_mx      = '0;
        exp_my      = '0;
        file_errors = 0;
        load_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge in);
        @(negedge in);
        rst_n = 1'b1;
        foreach (lines[i]) begin
            apply_line(lines[i]);
        end
        @(negedge in);
        cmd_valid = 1'b0;
        pix_valid = 1'b0;
        // wait for the pipeline to drain
        @(posedge in);
        while (pending != 0) begin
            @(posedge in);
        end
        repeat (2) @(posedge in);
        $display("errors: %0d mismatches, %0d unexpected outputs, %0d stimulus file errors",
                 mismatches, unexpected, file_errors);
        if (mismatches + unexpected + file_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog scaled to the stimulus length
    initial begin
        int limit;
        wait (loaded);
        limit = (lines.size() + 20) * PERIOD * 4;
        #(limit);
        $display("timeout: run exceeded %0d time units with %0d samples still pending",
                 limit, pending);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== testbench/stimulus_input.txt ====
# W addr data in hex | I n idle cycles
# P cam x y depth conf exp_accept exp_zone exp_mx exp_my, all decimal
P 0 200 200 1000 10 1 0 200 200
P 0 260 230 1000 10 1 1 260 230
P 1 10 20 1000 10 1 15 10 20
P 0 511 479 1000 10 1 15 511 479
P 0 512 100 1000 10 0 15 512 100
P 0 200 210 32768 0 0 0 200 210
I 4
W 0010 00000080
W 0012 000002a0
W 0014 00000080
W 0015 fffffec0
W 0016 00012345
W 0018 0000abcd
W 0020 00000000
W 0021 00000040
W 0023 00000040
W 0024 00000000
I 2
P 0 100 110 1000 10 1 0 210 215
P 1 150 250 1000 10 1 1 250 150
P 0 300 100 1000 10 0 15 610 195
P 0 0 0 1000 10 0 15 10 65531
P 0 40000 100 1000 10 0 15 14474 195
I 4
W 0010 00000040
W 0012 00000000
W 0014 00000040
W 0015 00000000
W 0080 00000064
W 0081 00000032
W 0082 0000003c
W 0083 00000014
W 0052 00000064
W 0002 00001388
W 0055 0000012c
W 0005 00002328
I 2
P 0 300 100 1000 10 1 4 300 100
P 0 300 99 1000 10 0 4 300 99
P 0 50 300 1000 10 1 7 50 300
P 0 49 300 1000 10 0 8 49 300
P 0 300 540 1000 10 0 15 300 540
P 0 532 300 1000 10 0 15 532 300
P 1 60 200 1000 10 1 4 200 60
P 1 59 200 1000 10 0 4 200 59
P 0 300 200 5000 100 1 2 300 200
P 0 300 200 5001 100 0 2 300 200
P 0 300 200 5000 99 0 2 300 200
P 0 350 200 9000 300 1 5 350 200
P 0 350 200 9001 300 0 5 350 200
P 0 350 200 9000 299 0 5 350 200
P 0 320 200 30000 0 1 3 320 200

// ==== sources.f ====
design/cfg_map_pkg.sv
design/pixel_pkg.sv
design/config_controller.sv
design/coord_xform.sv
design/roi_window.sv
design/zone_gate.sv
design/dfd_frontend_top.sv
testbench/tb_clock_gen.sv
testbench/dfd_frontend_checker.sv
testbench/dfd_frontend_monitor.sv
testbench/dfd_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the front end testbench with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dfd_frontend_tb -f sources.f

./obj_dir/Vdfd_frontend_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
